//--- affine_mc_control.sv
/* Top of the affine MC controller, sequencer followed by strobe register */
`default_nettype none

module affine_mc_control (
    input  wire                              CLK_CTRL,
    input  wire                              RESET_ALL,
    input  wire                              start,
    input  wire affine_mc_pkg::interp_mode_t mode,
    input  wire affine_mc_pkg::block_pos_t   pos,
    input  wire affine_mc_pkg::loop_status_t loops,
    output wire affine_mc_pkg::mvgen_ctrl_t  mvgen_ctrl,
    output wire affine_mc_pkg::interp_ctrl_t interp_ctrl,
    output wire                              flag_int_out,
    output wire                              done_all
);

    wire affine_mc_pkg::mc_state_t state;

    // --------------------------------------------------
    // Stage 1, state sequencing
    // --------------------------------------------------
    block_sequencer block_sequencer_inst (
        .CLK_CTRL  (CLK_CTRL),
        .RESET_ALL (RESET_ALL),
        .start     (start),
        .mode      (mode),
        .pos       (pos),
        .loops     (loops),
        .state     (state)
    );

    // --------------------------------------------------
    // Stage 2, registered strobes
    // --------------------------------------------------
    ctrl_strobe_register ctrl_strobe_register_inst (
        .CLK_CTRL     (CLK_CTRL),
        .RESET_ALL    (RESET_ALL),
        .state        (state),
        .mvgen_ctrl   (mvgen_ctrl),
        .interp_ctrl  (interp_ctrl),
        .flag_int_out (flag_int_out),
        .done_all     (done_all)
    );

endmodule

`default_nettype wire

//--- affine_mc_control_assert.sv
/* Concurrent checks on the registered strobes, bound to ctrl_strobe_register */
`default_nettype none

module affine_mc_control_assert (
    input wire                              CLK_CTRL,
    input wire                              RESET_ALL,
    input wire affine_mc_pkg::mvgen_ctrl_t  mvgen_ctrl,
    input wire affine_mc_pkg::interp_ctrl_t interp_ctrl,
    input wire                              done_all
);

    // Done is a single-cycle pulse
    done_single_pulse: assert property (@(posedge CLK_CTRL) disable iff (!RESET_ALL)
        done_all |=> !done_all)
        else $error("done_all high on two cycles in a row");

    coords_not_with_gen_mvs: assert property (@(posedge CLK_CTRL) disable iff (!RESET_ALL)
        !(mvgen_ctrl.write_coords && mvgen_ctrl.write_gen_mvs))
        else $error("write_coords together with write_gen_mvs");

    // Counter reset only on a block step, once out of reset
    counter_rst_with_step: assert property (@(posedge CLK_CTRL) disable iff (!RESET_ALL)
        (interp_ctrl.rst_n && !interp_ctrl.counter_rst_n) |-> mvgen_ctrl.write_count_block)
        else $error("counter_rst_n low without write_count_block");

endmodule

bind ctrl_strobe_register affine_mc_control_assert affine_mc_control_assert_inst (
    .CLK_CTRL    (CLK_CTRL),
    .RESET_ALL   (RESET_ALL),
    .mvgen_ctrl  (mvgen_ctrl),
    .interp_ctrl (interp_ctrl),
    .done_all    (done_all)
);

`default_nettype wire

//--- affine_mc_control_tb.sv
/* Testbench for the affine MC controller with a table of runs, a datapath model,
   compare tasks and a cycle timeout */
`default_nettype none

module affine_mc_control_tb;

    import affine_mc_pkg::*;

    typedef struct packed {
        int           lines;
        int           cols;
        interp_mode_t mode;
    } run_row_t;

    localparam int NUM_RUNS = 6;
    // Lines, columns and fraction mode of each run
    localparam run_row_t RUNS [NUM_RUNS] = '{
        '{1, 1, 2'b00},
        '{2, 3, 2'b10},
        '{3, 2, 2'b01},
        '{2, 2, 2'b11},
        '{1, 4, 2'b00},
        '{3, 1, 2'b11}
    };

    // Outputs in an idle state with the datapath out of reset
    localparam mvgen_ctrl_t  MV_IDLE = '{rst_n: 1'b1, default: 1'b0};
    localparam interp_ctrl_t IP_IDLE = '{rst_n: 1'b1, counter_rst_n: 1'b1, default: 1'b0};

    logic         CLK_CTRL  = 1'b0;
    logic         RESET_ALL = 1'b0;
    logic         start     = 1'b0;
    interp_mode_t mode      = '0;
    block_pos_t   pos       = '0;
    loop_status_t loops     = '0;
    mvgen_ctrl_t  mvgen_ctrl;
    interp_ctrl_t interp_ctrl;
    logic         flag_int_out;
    logic         done_all;

    logic [31:0] rng_state = 32'h8e643862;
    int run_lines   = 1;
    int run_cols    = 1;
    int cycle_count = 0;
    int gen_total   = 0;
    int cb_total    = 0;
    int selx_total  = 0;
    int done_total  = 0;
    int dim_total   = 0;
    int buf_total   = 0;
    int flag_total  = 0;

    affine_mc_control affine_mc_control_inst (
        .CLK_CTRL     (CLK_CTRL),
        .RESET_ALL    (RESET_ALL),
        .start        (start),
        .mode         (mode),
        .pos          (pos),
        .loops        (loops),
        .mvgen_ctrl   (mvgen_ctrl),
        .interp_ctrl  (interp_ctrl),
        .flag_int_out (flag_int_out),
        .done_all     (done_all)
    );

    always #20 CLK_CTRL = ~CLK_CTRL;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Each flag high while the count is below its limit minus one
    function automatic loop_status_t limit_flags(input int count);
        loop_status_t f;
        f.loop_3  = count < 2;
        f.loop_4  = count < 3;
        f.loop_9  = count < 8;
        f.loop_13 = count < 12;
        return f;
    endfunction

    // MV generator strobes seen at each edge from the start sample on
    function automatic mvgen_ctrl_t prologue_expect(input int step);
        mvgen_ctrl_t e;
        e = MV_IDLE;
        case (step)
            2: e.write_coords = 1'b1;
            3: begin
                e.write_cpmvs = 1'b1;
                e.write_x     = 1'b1;
                e.write_y     = 1'b1;
            end
            4: e.write_gen_mvs = 1'b1;
            default: e = MV_IDLE;
        endcase
        return e;
    endfunction

    function automatic int timeout_limit();
        int sum;
        sum = 200;
        for (int i = 0; i < NUM_RUNS; i++) begin
            sum += RUNS[i].lines * RUNS[i].cols * 40;
        end
        return sum;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Stopping on first error");
    endtask

    task automatic check_mvgen(input string name, input mvgen_ctrl_t got, input mvgen_ctrl_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_interp(input string name, input interp_ctrl_t got,
                                input interp_ctrl_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // Datapath model
    // --------------------------------------------------
    always @(posedge CLK_CTRL) begin : datapath_model
        int         count;
        int         line;
        int         col;
        block_pos_t p;
        // New run starts from a cleared counter
        if (!interp_ctrl.counter_rst_n || mvgen_ctrl.write_coords) begin
            count = 0;
        end else if (interp_ctrl.write_counter || interp_ctrl.write_int_out) begin
            count = count + 1;
        end
        if (mvgen_ctrl.write_x) begin
            line = mvgen_ctrl.sel_x ? line + 1 : 0;
        end
        if (mvgen_ctrl.write_y) begin
            col = mvgen_ctrl.sel_y ? col + 1 : 0;
        end
        p.ctrl_x = line < run_lines - 1;
        p.ctrl_y = col < run_cols - 1;
        pos   <= p;
        loops <= limit_flags(count);
    end

    // Pulse counters and timeout
    always @(posedge CLK_CTRL) begin : monitor
        cycle_count <= cycle_count + 1;
        if (mvgen_ctrl.write_gen_mvs) gen_total <= gen_total + 1;
        if (mvgen_ctrl.write_count_block) cb_total <= cb_total + 1;
        if (mvgen_ctrl.sel_x) selx_total <= selx_total + 1;
        if (done_all) done_total <= done_total + 1;
        if (interp_ctrl.sel_dimension) dim_total <= dim_total + 1;
        if (interp_ctrl.write_buffer && interp_ctrl.sel_buffer_in) buf_total <= buf_total + 1;
        if (flag_int_out) flag_total <= flag_total + 1;
        if (cycle_count >= timeout_limit()) begin
            report_failure($sformatf("Timeout: runs not finished after %0d cycles", cycle_count));
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin : stimulus
        int snap_gen;
        int snap_cb;
        int snap_selx;
        int snap_done;
        int snap_dim;
        int snap_buf;
        int snap_flag;
        int blocks;
        for (int i = 0; i < 8; i++) begin
            @(posedge CLK_CTRL);
            if (i > 0) begin
                check_mvgen("mvgen_ctrl", mvgen_ctrl, '0);
                check_interp("interp_ctrl", interp_ctrl, '0);
                check_bit("flag_int_out", flag_int_out, 1'b0);
                check_bit("done_all", done_all, 1'b0);
            end
            if (i == 7) RESET_ALL <= 1'b1;
        end
        @(posedge CLK_CTRL);
        check_mvgen("mvgen_ctrl", mvgen_ctrl, '0);
        check_interp("interp_ctrl", interp_ctrl, '0);
        check_bit("flag_int_out", flag_int_out, 1'b0);
        check_bit("done_all", done_all, 1'b0);
        @(posedge CLK_CTRL);
        check_mvgen("mvgen_ctrl", mvgen_ctrl, MV_IDLE);
        check_interp("interp_ctrl", interp_ctrl, IP_IDLE);

        for (int r = 0; r < NUM_RUNS; r++) begin
            @(posedge CLK_CTRL);
            mode      <= RUNS[r].mode;
            run_lines <= RUNS[r].lines;
            run_cols  <= RUNS[r].cols;
            start     <= 1'b1;
            blocks    = RUNS[r].lines * RUNS[r].cols;
            snap_gen  = gen_total;
            snap_cb   = cb_total;
            snap_selx = selx_total;
            snap_done = done_total;
            snap_dim  = dim_total;
            snap_buf  = buf_total;
            snap_flag = flag_total;
            // Start is sampled at step 0 and toggles at random afterwards
            for (int step = 0; step < 5; step++) begin
                @(posedge CLK_CTRL);
                rng_state = xorshift32(rng_state);
                start <= rng_state[0] && (pos.ctrl_x || pos.ctrl_y);
                check_mvgen("mvgen_ctrl", mvgen_ctrl, prologue_expect(step));
            end
            // Start held low once the last sub-block is reached
            while (done_total == snap_done) begin
                @(posedge CLK_CTRL);
                rng_state = xorshift32(rng_state);
                start <= rng_state[0] && (pos.ctrl_x || pos.ctrl_y);
            end
            start <= 1'b0;
            repeat (3) @(posedge CLK_CTRL);
            check_count("write_gen_mvs pulses", gen_total - snap_gen, blocks);
            check_count("write_count_block pulses", cb_total - snap_cb, blocks - 1);
            check_count("sel_x pulses", selx_total - snap_selx, RUNS[r].lines - 1);
            check_count("done_all pulses", done_total - snap_done, 1);
            check_bit("sel_dimension seen", dim_total != snap_dim, RUNS[r].mode.interp_x);
            check_bit("buffered write seen", buf_total != snap_buf, RUNS[r].mode == 2'b01);
            check_bit("flag_int_out seen", flag_total != snap_flag,
                      RUNS[r].mode.interp_x == RUNS[r].mode.interp_y);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- affine_mc_pkg.sv
/* Shared types for the affine MC controller:
   state encoding, datapath status flags and control strobe structs */
`default_nettype none

package affine_mc_pkg;

    // --------------------------------------------------
    // Controller state
    // --------------------------------------------------
    typedef enum logic [3:0] {
        s_idle          = 4'd0,
        s_load_mvgen_in = 4'd1,
        s_mvgen_init    = 4'd2,
        s_mvgen_done    = 4'd3,
        s_int_decision  = 4'd4,
        s_load_buffer   = 4'd5,
        s_int_x         = 4'd6,
        s_int_y         = 4'd7,
        s_int_xy_h      = 4'd8,
        s_int_xy_v      = 4'd9,
        s_skip          = 4'd10,
        s_loop1         = 4'd11,
        s_loop2         = 4'd12,
        s_next_line     = 4'd13,
        s_next_column   = 4'd14,
        s_done          = 4'd15
    } mc_state_t;

    // --------------------------------------------------
    // Status from the datapath
    // --------------------------------------------------
    // Fractional parts of the generated MV
    typedef struct packed {
        logic interp_x;
        logic interp_y;
    } interp_mode_t;

    // ctrl_x: more lines left, ctrl_y: more columns left in this line
    typedef struct packed {
        logic ctrl_x;
        logic ctrl_y;
    } block_pos_t;

    // Interpolator counter below each limit
    typedef struct packed {
        logic loop_3;
        logic loop_4;
        logic loop_9;
        logic loop_13;
    } loop_status_t;

    // --------------------------------------------------
    // Control strobes
    // --------------------------------------------------
    // MV generator, rst_n is active low
    typedef struct packed {
        logic rst_n;
        logic write_coords;
        logic write_cpmvs;
        logic write_gen_mvs;
        logic write_x;
        logic write_y;
        logic write_count_block;
        logic sel_x;
        logic sel_y;
    } mvgen_ctrl_t;

    // Interpolator, both resets active low
    typedef struct packed {
        logic rst_n;
        logic counter_rst_n;
        logic write_input_line;
        logic write_counter;
        logic write_int_out;
        logic write_buffer;
        logic sel_buffer_in;
        logic sel_line_in;
        logic sel_dimension;
    } interp_ctrl_t;

endpackage

`default_nettype wire

//--- all.f
affine_mc_pkg.sv
block_sequencer.sv
ctrl_strobe_register.sv
affine_mc_control.sv
affine_mc_control_assert.sv
affine_mc_control_tb.sv

//--- block_sequencer.sv
/* State register and next-state logic of the affine MC controller */
`default_nettype none

module block_sequencer (
    input  wire                              CLK_CTRL,
    input  wire                              RESET_ALL,
    input  wire                              start,
    input  wire affine_mc_pkg::interp_mode_t mode,
    input  wire affine_mc_pkg::block_pos_t   pos,
    input  wire affine_mc_pkg::loop_status_t loops,
    output affine_mc_pkg::mc_state_t         state
);

    import affine_mc_pkg::*;

    mc_state_t state_next;
    mc_state_t step_target;
    mc_state_t loop1_target;
    logic      loop1_more;

    // --------------------------------------------------
    // Helper decisions
    // --------------------------------------------------
    // Where a finished sub-block goes
    always_comb begin
        if (pos.ctrl_y) begin
            step_target = s_next_column;
        end else if (pos.ctrl_x) begin
            step_target = s_next_line;
        end else begin
            step_target = s_done;
        end
    end

    // Vertical filters need 13 taps worth of passes, horizontal only 4
    assign loop1_more = mode.interp_y ? loops.loop_13 : loops.loop_4;

    // Re-entry point of the interpolation loop
    always_comb begin
        case ({mode.interp_x, mode.interp_y})
            2'b10: loop1_target = s_int_x;
            2'b01: loop1_target = s_int_y;
            2'b11: loop1_target = s_int_xy_h;
            default: loop1_target = step_target;
        endcase
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (start) begin
                    state_next = s_load_mvgen_in;
                end
            end
            s_load_mvgen_in: begin
                state_next = s_mvgen_init;
            end
            s_mvgen_init: begin
                state_next = s_mvgen_done;
            end
            s_mvgen_done: begin
                state_next = s_int_decision;
            end
            s_int_decision: begin
                case ({mode.interp_x, mode.interp_y})
                    2'b00: state_next = s_skip;
                    2'b10: state_next = s_int_x;
                    2'b01: state_next = s_load_buffer;
                    default: state_next = s_int_xy_h;
                endcase
            end
            // Integer MV, copy samples straight through
            s_skip: begin
                if (!loops.loop_3) begin
                    state_next = step_target;
                end
            end
            // Vertical only, fill the line buffer first
            s_load_buffer: begin
                if (!loops.loop_9) begin
                    state_next = s_int_y;
                end
            end
            s_int_x, s_int_y, s_int_xy_v: begin
                state_next = s_loop1;
            end
            s_int_xy_h: begin
                state_next = s_loop2;
            end
            s_loop2: begin
                if (!loops.loop_9) begin
                    state_next = s_int_xy_v;
                end
            end
            s_loop1: begin
                if (loop1_more) begin
                    state_next = loop1_target;
                end else begin
                    state_next = step_target;
                end
            end
            s_next_line, s_next_column: begin
                state_next = s_mvgen_done;
            end
            s_done: begin
                state_next = s_idle;
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge CLK_CTRL or negedge RESET_ALL) begin
        if (!RESET_ALL) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

//--- ctrl_strobe_register.sv
/* State decoder and output register for the MV generator
   and interpolator strobes */
`default_nettype none

module ctrl_strobe_register (
    input  wire                           CLK_CTRL,
    input  wire                           RESET_ALL,
    input  wire affine_mc_pkg::mc_state_t state,
    output affine_mc_pkg::mvgen_ctrl_t    mvgen_ctrl,
    output affine_mc_pkg::interp_ctrl_t   interp_ctrl,
    output logic                          flag_int_out,
    output logic                          done_all
);

    import affine_mc_pkg::*;

    // Datapath out of reset, nothing written
    localparam mvgen_ctrl_t MVGEN_RUN = '{
        rst_n:   1'b1,
        default: 1'b0
    };
    localparam interp_ctrl_t INTERP_RUN = '{
        rst_n:         1'b1,
        counter_rst_n: 1'b1,
        default:       1'b0
    };

    mvgen_ctrl_t  mvgen_next;
    interp_ctrl_t interp_next;
    logic         flag_next;
    logic         done_next;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    always_comb begin
        mvgen_next  = MVGEN_RUN;
        interp_next = INTERP_RUN;
        flag_next   = 1'b0;
        done_next   = 1'b0;
        case (state)
            s_idle: begin
                // Waiting for start, all strobes quiet
            end
            s_load_mvgen_in: begin
                mvgen_next.write_coords = 1'b1;
            end
            s_mvgen_init: begin
                mvgen_next.write_cpmvs = 1'b1;
                mvgen_next.write_x     = 1'b1;
                mvgen_next.write_y     = 1'b1;
            end
            s_mvgen_done: begin
                mvgen_next.write_gen_mvs = 1'b1;
            end
            s_int_decision: begin
                interp_next.write_input_line = 1'b1;
            end
            s_load_buffer: begin
                interp_next.write_input_line = 1'b1;
                interp_next.write_counter    = 1'b1;
                interp_next.write_buffer     = 1'b1;
                interp_next.sel_buffer_in    = 1'b1;
            end
            // Horizontal pass reads the input line, along X
            s_int_x, s_int_xy_h: begin
                interp_next.write_input_line = 1'b1;
                interp_next.write_counter    = 1'b1;
                interp_next.sel_line_in      = 1'b1;
                interp_next.sel_dimension    = 1'b1;
            end
            // Vertical pass reads from the buffer
            s_int_y, s_int_xy_v: begin
                interp_next.write_counter = 1'b1;
            end
            s_skip: begin
                interp_next.write_input_line = 1'b1;
                interp_next.write_counter    = 1'b1;
                interp_next.write_int_out    = 1'b1;
                interp_next.sel_buffer_in    = 1'b1;
                flag_next                    = 1'b1;
            end
            s_loop1: begin
                interp_next.write_buffer = 1'b1;
            end
            s_loop2: begin
                interp_next.write_int_out = 1'b1;
                flag_next                 = 1'b1;
            end
            // New line restarts Y from the origin column
            s_next_line: begin
                mvgen_next.write_x           = 1'b1;
                mvgen_next.write_y           = 1'b1;
                mvgen_next.write_count_block = 1'b1;
                mvgen_next.sel_x             = 1'b1;
                interp_next.counter_rst_n    = 1'b0;
            end
            s_next_column: begin
                mvgen_next.write_y           = 1'b1;
                mvgen_next.write_count_block = 1'b1;
                mvgen_next.sel_y             = 1'b1;
                interp_next.counter_rst_n    = 1'b0;
            end
            s_done: begin
                done_next = 1'b1;
            end
            default: begin
                done_next = 1'b0;
            end
        endcase
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    // Reset drives all active-low resets low too
    always_ff @(posedge CLK_CTRL or negedge RESET_ALL) begin
        if (!RESET_ALL) begin
            mvgen_ctrl   <= '0;
            interp_ctrl  <= '0;
            flag_int_out <= 1'b0;
            done_all     <= 1'b0;
        end else begin
            mvgen_ctrl   <= mvgen_next;
            interp_ctrl  <= interp_next;
            flag_int_out <= flag_next;
            done_all     <= done_next;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it, exit status reflects the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module affine_mc_control_tb -o tb_sim &&
./obj_dir/tb_sim ||
{ echo "Build or simulation failed"; exit 1; }
